/* files.f */
+incdir+verilog
+incdir+testbench
verilog/cryptTypesPkg.sv
verilog/pathCtrlPkg.sv
verilog/streamFifo.sv
verilog/keystreamGen.sv
verilog/bucketSequencer.sv
verilog/pathSequencer.sv
verilog/pathCrypt.sv
testbench/pathCryptTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the path encryption testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
SIM_BIN=pathCryptSim

verilator --binary --timing --assert -Wno-fatal \
    -f files.f --top-module pathCryptTb \
    --Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" "$LOG"; then
    exit 1
fi
exit 0

/* testbench/pathCryptModel.svh */
// --------------------------------------------------------------------------
// Reference model of the keystream rounds and the expected bursts of a path
// --------------------------------------------------------------------------
`ifndef PATHCRYPTMODEL_SVH
`define PATHCRYPTMODEL_SVH

`include "pathCrypt_macros.svh"

// Keystream block for one IV and burst index
function automatic logic [`PC_DATA_WIDTH-1:0] modelKeystream(
    input logic [`PC_IV_WIDTH-1:0]              iv,
    input logic [$clog2(`PC_BUCKET_BURSTS)-1:0] idx
);
    logic [`PC_DATA_WIDTH-1:0] blk;
    logic [`PC_DATA_WIDTH-1:0] roundNum;
    int                        r;
    blk = '0;
    blk[`PC_IV_WIDTH-1:0] = iv;
    blk[`PC_IV_WIDTH +: $clog2(`PC_BUCKET_BURSTS)] = idx;
    for (r = 1; r <= `PC_KEY_ROUNDS; r++) begin
        roundNum = r;
        blk = blk ^ `PC_KEY;
        // Rotate left
        blk = {blk[`PC_DATA_WIDTH-`PC_ROTATE-1:0], blk[`PC_DATA_WIDTH-1 -: `PC_ROTATE]};
        blk = blk + `PC_ROUND_CONST * roundNum;
    end
    return blk;
endfunction

// Expected bursts of a whole path, the header IV stays plain
function automatic void modelPath(
    input  logic [`PC_DATA_WIDTH-1:0] data     [`PC_PATH_BUCKETS * `PC_BUCKET_BURSTS],
    output logic [`PC_DATA_WIDTH-1:0] expected [`PC_PATH_BUCKETS * `PC_BUCKET_BURSTS]
);
    logic [`PC_IV_WIDTH-1:0]              iv;
    logic [$clog2(`PC_BUCKET_BURSTS)-1:0] idx;
    int                                   i;
    iv  = '0;
    idx = '0;
    for (i = 0; i < `PC_PATH_BUCKETS * `PC_BUCKET_BURSTS; i++) begin
        if (idx == 0) begin
            iv = data[i][`PC_IV_WIDTH-1:0];
        end
        expected[i] = data[i] ^ modelKeystream(iv, idx);
        if (idx == 0) begin
            expected[i][`PC_IV_WIDTH-1:0] = iv;
        end
        idx = idx + 1'b1;
    end
endfunction

`endif

/* testbench/pathCryptTb.sv */
// --------------------------------------------------------------------------
// Testbench for the path encryption layer
// Stimulus, reference model comparison and reporting
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "pathCrypt_macros.svh"

module pathCryptTb
    import cryptTypesPkg::*;
    import pathCtrlPkg::*;
();

    localparam int PathLen    = `PC_PATH_BUCKETS * `PC_BUCKET_BURSTS;
    localparam int WaitLimit  = 200;
    localparam int DrainLimit = 400;

    typedef burstT pathArrT [PathLen];

    `include "pathCryptModel.svh"

    logic  Clock           = 1'b0;
    logic  rstN            = 1'b0;
    burstT dramIn          = '0;
    logic  dramInValid     = 1'b0;
    logic  dramInReady;
    burstT backendIn       = '0;
    logic  backendInValid  = 1'b0;
    logic  backendInReady;
    burstT dramOut;
    logic  dramOutValid;
    logic  dramOutReady    = 1'b1;
    burstT backendOut;
    logic  backendOutValid;
    logic  backendOutReady = 1'b1;

    int          dataSeed    = 77973;
    int          readySeed   = 77973;
    logic [31:0] readyBits;
    bit          randomReady = 1'b0;
    bit          capture     = 1'b0;
    bit          aborted     = 1'b0;
    int          errCount    = 0;
    int          testCount   = 0;
    int          failCount   = 0;
    int          testErrStart;
    int          outIndex;
    string       curTest     = "reset";

    // Pending outputs, in input order
    burstT                   expData   [$];
    pathDirT                 expDir    [$];
    bit                      expHeader [$];
    logic [`PC_IV_WIDTH-1:0] expPlain  [$];
    burstT                   captured  [$];

    pathCrypt dut (.*);

    always #20 Clock = ~Clock;

    // Out-ready, optionally random for back-pressure
    always @(negedge Clock) begin
        if (randomReady) begin
            readyBits       = $random(readySeed);
            dramOutReady    = readyBits[0];
            backendOutReady = readyBits[1];
        end else begin
            dramOutReady    = 1'b1;
            backendOutReady = 1'b1;
        end
    end

    function automatic burstT randomBurst();
        return {$random(dataSeed), $random(dataSeed)};
    endfunction

    function automatic void fillRandom(output pathArrT data);
        for (int i = 0; i < PathLen; i++) begin
            data[i] = randomBurst();
        end
    endfunction

    // --------------------------------------------------------------------------
    // Comparison
    // --------------------------------------------------------------------------

    task automatic checkOutput(input pathDirT port, input burstT actual);
        burstT                   wantData;
        pathDirT                 wantDir;
        bit                      isHeader;
        logic [`PC_IV_WIDTH-1:0] plainIv;
        assert (expData.size() != 0) else begin
            $display("Output burst %h arrived with nothing pending in test %s", actual, curTest);
            errCount++;
        end
        if (expData.size() != 0) begin
            wantData = expData.pop_front();
            wantDir  = expDir.pop_front();
            isHeader = expHeader.pop_front();
            plainIv  = expPlain.pop_front();
            assert (port == wantDir) else begin
                $display("Burst %0d of test %s left on the wrong port", outIndex, curTest);
                errCount++;
            end
            assert (actual == wantData) else begin
                $display("ERR %s burst %0d: expected %h, actual %h",
                         curTest, outIndex, wantData, actual);
                errCount++;
            end
            if (isHeader) begin
                assert (actual[`PC_IV_WIDTH-1:0] == plainIv) else begin
                    $display("ERR %s header IV of burst %0d: expected %h, actual %h",
                             curTest, outIndex, plainIv, actual[`PC_IV_WIDTH-1:0]);
                    errCount++;
                end
            end
            if (capture && port == pathWrite) begin
                captured.push_back(actual);
            end
            outIndex++;
        end
    endtask

    always @(posedge Clock) begin
        if (rstN) begin
            assert (!(dramOutValid && backendOutValid)) else begin
                $display("Both outputs were valid in the same cycle in test %s", curTest);
                errCount++;
            end
            if (backendOutValid && backendOutReady) begin
                checkOutput(pathRead, backendOut);
            end
            if (dramOutValid && dramOutReady) begin
                checkOutput(pathWrite, dramOut);
            end
        end
    end

    // --------------------------------------------------------------------------
    // Stimulus
    // --------------------------------------------------------------------------

    // One path on the input of its direction, noise on the idle input
    task automatic sendPath(input pathDirT dir, input pathArrT data,
                            input pathArrT expected, input bit noise);
        int i;
        int cycles;
        bit accepted;
        @(negedge Clock);
        if (noise && dir == pathRead) begin
            backendIn      = randomBurst();
            backendInValid = 1'b1;
        end else if (noise) begin
            dramIn      = randomBurst();
            dramInValid = 1'b1;
        end
        for (i = 0; i < PathLen && !aborted; i++) begin
            if (i != 0) begin
                @(negedge Clock);
            end
            if (dir == pathRead) begin
                dramIn      = data[i];
                dramInValid = 1'b1;
            end else begin
                backendIn      = data[i];
                backendInValid = 1'b1;
            end
            cycles   = 0;
            accepted = 1'b0;
            while (!accepted && cycles < WaitLimit) begin
                @(posedge Clock);
                cycles++;
                accepted = (dir == pathRead) ? dramInReady : backendInReady;
                assert (((dir == pathRead) ? backendInReady : dramInReady) == 1'b0) else begin
                    $display("Idle input port was ready in test %s", curTest);
                    errCount++;
                end
            end
            if (accepted) begin
                expData.push_back(expected[i]);
                expDir.push_back(dir);
                expHeader.push_back((i % `PC_BUCKET_BURSTS) == 0);
                expPlain.push_back(data[i][`PC_IV_WIDTH-1:0]);
            end else begin
                $display("Timeout: input burst %0d was never accepted in test %s", i, curTest);
                aborted = 1'b1;
            end
        end
        @(negedge Clock);
        dramInValid    = 1'b0;
        backendInValid = 1'b0;
    endtask

    task automatic waitDrain();
        int cycles;
        cycles = 0;
        while (!aborted && expData.size() != 0 && cycles < DrainLimit) begin
            @(negedge Clock);
            cycles++;
        end
        if (!aborted && expData.size() != 0) begin
            $display("Timeout: %0d output bursts never arrived in test %s",
                     expData.size(), curTest);
            aborted = 1'b1;
        end
    endtask

    task automatic checkResetState();
        int cycles;
        @(negedge Clock);
        backendIn      = randomBurst();
        backendInValid = 1'b1;
        for (cycles = 0; cycles < 4; cycles++) begin
            @(posedge Clock);
            assert (!dramOutValid && !backendOutValid) else begin
                $display("An output was valid right after reset");
                errCount++;
            end
            assert (dramInReady && !backendInReady) else begin
                $display("First path was not open only on the DRAM input");
                errCount++;
            end
        end
        @(negedge Clock);
        backendInValid = 1'b0;
    endtask

    task automatic startTest(input string name);
        curTest      = name;
        testErrStart = errCount;
        outIndex     = 0;
    endtask

    task automatic finishTest();
        testCount++;
        if (errCount == testErrStart && !aborted) begin
            $display("PASS  %s", curTest);
        end else begin
            failCount++;
            $display("FAIL  %s, %0d check errors", curTest, errCount - testErrStart);
        end
    endtask

    task automatic runPath(input pathDirT dir, input pathArrT data, input pathArrT expected);
        sendPath(dir, data, expected, 1'b0);
        waitDrain();
    endtask

    // --------------------------------------------------------------------------
    // Test sequence
    // --------------------------------------------------------------------------

    initial begin
        pathArrT data;
        pathArrT expected;
        pathArrT writeData;
        pathDirT dir;
        int      p;
        rstN = 1'b0;
        repeat (16) @(posedge Clock);
        @(negedge Clock);
        rstN = 1'b1;

        startTest("reset state");
        checkResetState();
        finishTest();

        startTest("read path");
        fillRandom(data);
        modelPath(data, expected);
        runPath(pathRead, data, expected);
        finishTest();

        startTest("write path");
        fillRandom(writeData);
        modelPath(writeData, expected);
        captured.delete();
        capture = 1'b1;
        runPath(pathWrite, writeData, expected);
        capture = 1'b0;
        finishTest();

        // Ciphertext from the write path goes back through a read path
        startTest("read restores write data");
        assert (captured.size() == PathLen) else begin
            $display("Write path captured %0d bursts instead of %0d", captured.size(), PathLen);
            errCount++;
        end
        for (p = 0; p < PathLen; p++) begin
            data[p] = (p < captured.size()) ? captured[p] : '0;
        end
        runPath(pathRead, data, writeData);
        finishTest();

        startTest("header IV passthrough");
        fillRandom(data);
        modelPath(data, expected);
        runPath(pathWrite, data, expected);
        finishTest();

        startTest("back-pressure");
        randomReady = 1'b1;
        fillRandom(data);
        modelPath(data, expected);
        runPath(pathRead, data, expected);
        randomReady = 1'b0;
        finishTest();

        startTest("direction alternation");
        for (p = 0; p < 4; p++) begin
            dir = (p % 2 == 0) ? pathWrite : pathRead;
            fillRandom(data);
            modelPath(data, expected);
            sendPath(dir, data, expected, 1'b1);
            waitDrain();
        end
        finishTest();

        $display("Tests run: %0d, failed: %0d, check errors: %0d",
                 testCount, failCount, errCount);
        if (errCount == 0 && failCount == 0 && !aborted) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* verilog/bucketSequencer.sv */
// --------------------------------------------------------------------------
// Bucket position tracking and IV capture
// Fans each burst out to the data FIFO and the keystream pipeline
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "pathCrypt_macros.svh"

module bucketSequencer
    import cryptTypesPkg::*;
    import pathCtrlPkg::*;
(
    input  logic       Clock,
    input  logic       rstN,
    input  burstT      rawIn,
    input  logic       rawValid,
    output logic       rawReady,
    output burstEntryT entryOut,
    output logic       entryValid,
    input  logic       entryReady,
    output nonceT      nonceOut,
    output logic       nonceValid,
    input  logic       nonceReady
);

    localparam burstIdxT LastIdx = burstIdxT'(`PC_BUCKET_BURSTS - 1);

    burstIdxT                burstIdx;
    logic [`PC_IV_WIDTH-1:0] ivReg;
    logic [`PC_IV_WIDTH-1:0] ivCur;
    logic                    isHeader;
    logic                    xfer;

    assign isHeader = (burstIdx == '0);

    // Later bursts reuse the IV captured from the header
    assign ivCur = isHeader ? rawIn[`PC_IV_WIDTH-1:0] : ivReg;

    // Both sinks must take the burst in the same cycle
    assign rawReady   = entryReady && nonceReady;
    assign entryValid = rawValid && nonceReady;
    assign nonceValid = rawValid && entryReady;
    assign xfer       = rawValid && rawReady;

    assign entryOut.isHeader = isHeader;
    assign entryOut.data     = rawIn;
    assign nonceOut.index    = burstIdx;
    assign nonceOut.iv       = ivCur;

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            burstIdx <= '0;
        end else if (xfer) begin
            burstIdx <= (burstIdx == LastIdx) ? '0 : burstIdx + 1'b1;
        end
    end

    always_ff @(posedge Clock) begin
        if (xfer && isHeader) begin
            ivReg <= rawIn[`PC_IV_WIDTH-1:0];
        end
    end

    // An offered burst holds still until both sinks take it
    assert property (@(posedge Clock) disable iff (!rstN)
        rawValid && !rawReady |=> rawValid && $stable(rawIn));

endmodule

/* verilog/cryptTypesPkg.sv */
// --------------------------------------------------------------------------
// Burst, nonce, keystream and data FIFO entry types
// --------------------------------------------------------------------------
`include "pathCrypt_macros.svh"

package cryptTypesPkg;

    // One DRAM burst
    typedef logic [`PC_DATA_WIDTH-1:0] burstT;

    // Keystream input, index sits just above the IV
    typedef struct packed {
        logic [$clog2(`PC_BUCKET_BURSTS)-1:0] index;
        logic [`PC_IV_WIDTH-1:0]              iv;
    } nonceT;

    // One keystream block, same width as a burst
    typedef logic [`PC_DATA_WIDTH-1:0] keyBlockT;

    // Data FIFO entry, the header flag rides along with the burst
    typedef struct packed {
        logic  isHeader;
        burstT data;
    } burstEntryT;

endpackage

/* verilog/keystreamGen.sv */
// --------------------------------------------------------------------------
// Keystream pipeline of keyed mixing rounds, credit-based input ready
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "pathCrypt_macros.svh"

module keystreamGen
    import cryptTypesPkg::*;
(
    input  logic                                 Clock,
    input  logic                                 rstN,
    input  nonceT                                nonceIn,
    input  logic                                 nonceValid,
    output logic                                 nonceReady,
    output keyBlockT                             keyOut,
    output logic                                 keyValid,
    input  logic [$clog2(`PC_FIFO_DEPTH+1)-1:0]  fifoCount
);

    localparam int Rounds  = `PC_KEY_ROUNDS;
    localparam int FlightW = $clog2(Rounds + 1);

    keyBlockT             stageData [Rounds];
    logic [Rounds-1:0]    stageValid;
    logic [FlightW-1:0]   inFlight;
    keyBlockT             startBlock;
    logic                 accept;

    // XOR key, rotate, then add the scaled round constant
    function automatic keyBlockT mixRound(keyBlockT blockIn, int stage);
        keyBlockT x;
        x = blockIn ^ `PC_KEY;
        x = (x << `PC_ROTATE) | (x >> (`PC_DATA_WIDTH - `PC_ROTATE));
        return x + `PC_ROUND_CONST * keyBlockT'(stage);
    endfunction

    // Nonce zero-extended, IV low and index above it
    assign startBlock = keyBlockT'(nonceIn);

    // Blocks in flight plus queued results must leave room in keyFifo
    assign nonceReady = (int'(inFlight) + int'(fifoCount)) < `PC_FIFO_DEPTH;
    assign accept     = nonceValid && nonceReady;

    for (genvar s = 0; s < Rounds; s++) begin : gRound
        if (s == 0) begin : gFirst
            always_ff @(posedge Clock) begin
                stageData[s] <= mixRound(startBlock, 1);
            end
        end else begin : gNext
            always_ff @(posedge Clock) begin
                stageData[s] <= mixRound(stageData[s-1], s + 1);
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            stageValid <= '0;
            inFlight   <= '0;
        end else begin
            stageValid <= {stageValid[Rounds-2:0], accept};
            case ({accept, keyValid})
                2'b10:   inFlight <= inFlight + 1'b1;
                2'b01:   inFlight <= inFlight - 1'b1;
                default: inFlight <= inFlight;
            endcase
        end
    end

    assign keyOut   = stageData[Rounds-1];
    assign keyValid = stageValid[Rounds-1];

    // The pipeline cannot stall, so keyFifo must have room for every result
    assert property (@(posedge Clock) disable iff (!rstN)
        keyValid |-> fifoCount != `PC_FIFO_DEPTH);

endmodule

/* verilog/pathCrypt.sv */
// --------------------------------------------------------------------------
// Top level of the path encryption layer between back end and DRAM
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "pathCrypt_macros.svh"

module pathCrypt
    import cryptTypesPkg::*;
(
    input  logic                      Clock,
    input  logic                      rstN,
    input  logic [`PC_DATA_WIDTH-1:0] dramIn,
    input  logic                      dramInValid,
    output logic                      dramInReady,
    input  logic [`PC_DATA_WIDTH-1:0] backendIn,
    input  logic                      backendInValid,
    output logic                      backendInReady,
    output logic [`PC_DATA_WIDTH-1:0] dramOut,
    output logic                      dramOutValid,
    input  logic                      dramOutReady,
    output logic [`PC_DATA_WIDTH-1:0] backendOut,
    output logic                      backendOutValid,
    input  logic                      backendOutReady
);

    burstT      rawData;
    logic       rawValid;
    logic       rawReady;
    burstEntryT entryTail;
    logic       entryTailValid;
    logic       entryTailReady;
    burstEntryT entryHead;
    logic       entryHeadValid;
    logic       entryHeadReady;
    nonceT      nonce;
    logic       nonceValid;
    logic       nonceReady;
    keyBlockT   keyBlock;
    logic       keyBlockValid;
    keyBlockT   keyHead;
    logic       keyHeadValid;
    logic       keyHeadReady;
    logic [$clog2(`PC_FIFO_DEPTH+1)-1:0] keyFifoCount;

    pathSequencer pathSeq (
        .Clock(Clock), .rstN(rstN),
        .dramIn(dramIn), .dramInValid(dramInValid), .dramInReady(dramInReady),
        .backendIn(backendIn), .backendInValid(backendInValid),
        .backendInReady(backendInReady),
        .rawOut(rawData), .rawValid(rawValid), .rawReady(rawReady),
        .entryIn(entryHead), .entryValid(entryHeadValid), .entryReady(entryHeadReady),
        .keyIn(keyHead), .keyValid(keyHeadValid), .keyReady(keyHeadReady),
        .dramOut(dramOut), .dramOutValid(dramOutValid), .dramOutReady(dramOutReady),
        .backendOut(backendOut), .backendOutValid(backendOutValid),
        .backendOutReady(backendOutReady)
    );

    bucketSequencer bucketSeq (
        .Clock(Clock), .rstN(rstN),
        .rawIn(rawData), .rawValid(rawValid), .rawReady(rawReady),
        .entryOut(entryTail), .entryValid(entryTailValid), .entryReady(entryTailReady),
        .nonceOut(nonce), .nonceValid(nonceValid), .nonceReady(nonceReady)
    );

    keystreamGen keyGen (
        .Clock(Clock), .rstN(rstN),
        .nonceIn(nonce), .nonceValid(nonceValid), .nonceReady(nonceReady),
        .keyOut(keyBlock), .keyValid(keyBlockValid), .fifoCount(keyFifoCount)
    );

    streamFifo #(.Payload(burstEntryT), .Depth(`PC_FIFO_DEPTH)) dataFifo (
        .Clock(Clock), .rstN(rstN),
        .inData(entryTail), .inValid(entryTailValid), .inReady(entryTailReady),
        .outData(entryHead), .outValid(entryHeadValid), .outReady(entryHeadReady),
        .count()
    );

    // Pipeline results enter without back-pressure, credit keeps room
    streamFifo #(.Payload(keyBlockT), .Depth(`PC_FIFO_DEPTH)) keyFifo (
        .Clock(Clock), .rstN(rstN),
        .inData(keyBlock), .inValid(keyBlockValid), .inReady(),
        .outData(keyHead), .outValid(keyHeadValid), .outReady(keyHeadReady),
        .count(keyFifoCount)
    );

endmodule

/* verilog/pathCrypt_macros.svh */
// --------------------------------------------------------------------------
// Widths, counts, key and round constants for the path encryption layer
// --------------------------------------------------------------------------
`ifndef PATHCRYPT_MACROS_SVH
`define PATHCRYPT_MACROS_SVH

// Burst and header geometry
`define PC_DATA_WIDTH       64
`define PC_IV_WIDTH         16

// Path shape
`define PC_BUCKET_BURSTS    4
`define PC_PATH_BUCKETS     3

// Keystream mixing, one round per pipeline stage
`define PC_KEY_ROUNDS       4
`define PC_KEY              64'h3C6E_F372_FE94_F82B
`define PC_ROUND_CONST      64'h9E37_79B9_7F4A_7C15
`define PC_ROTATE           13

// Buffering
`define PC_FIFO_DEPTH       8

`endif

/* verilog/pathCtrlPkg.sv */
// --------------------------------------------------------------------------
// Path direction and position counter types
// --------------------------------------------------------------------------
`include "pathCrypt_macros.svh"

package pathCtrlPkg;

    // Read is DRAM to back end, write is the reverse
    typedef enum logic {
        pathRead  = 1'b0,
        pathWrite = 1'b1
    } pathDirT;

    // Position within a bucket
    typedef logic [$clog2(`PC_BUCKET_BURSTS)-1:0] burstIdxT;

    // Bursts within a path, must reach the full path length
    typedef logic [$clog2(`PC_PATH_BUCKETS * `PC_BUCKET_BURSTS + 1)-1:0] pathCountT;

endpackage

/* verilog/pathSequencer.sv */
// --------------------------------------------------------------------------
// Path direction, input selection, keystream join and output routing
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "pathCrypt_macros.svh"

module pathSequencer
    import cryptTypesPkg::*;
    import pathCtrlPkg::*;
(
    input  logic       Clock,
    input  logic       rstN,
    input  burstT      dramIn,
    input  logic       dramInValid,
    output logic       dramInReady,
    input  burstT      backendIn,
    input  logic       backendInValid,
    output logic       backendInReady,
    output burstT      rawOut,
    output logic       rawValid,
    input  logic       rawReady,
    input  burstEntryT entryIn,
    input  logic       entryValid,
    output logic       entryReady,
    input  keyBlockT   keyIn,
    input  logic       keyValid,
    output logic       keyReady,
    output burstT      dramOut,
    output logic       dramOutValid,
    input  logic       dramOutReady,
    output burstT      backendOut,
    output logic       backendOutValid,
    input  logic       backendOutReady
);

    localparam pathCountT PathBursts = pathCountT'(`PC_PATH_BUCKETS * `PC_BUCKET_BURSTS);

    pathDirT   dir;
    pathCountT inCount;
    pathCountT outCount;
    logic      inOpen;
    logic      inXfer;
    burstT     joined;
    logic      joinValid;
    logic      outReadySel;
    logic      outXfer;
    logic      lastOut;

    // ------------------------------------------------------------------------
    // Input side
    // ------------------------------------------------------------------------

    // Closed once the whole path is in, until the direction flips
    assign inOpen = (inCount != PathBursts);

    assign rawOut   = (dir == pathRead) ? dramIn : backendIn;
    assign rawValid = inOpen && ((dir == pathRead) ? dramInValid : backendInValid);
    assign inXfer   = rawValid && rawReady;

    assign dramInReady    = inOpen && (dir == pathRead) && rawReady;
    assign backendInReady = inOpen && (dir == pathWrite) && rawReady;

    // ------------------------------------------------------------------------
    // Join and XOR
    // ------------------------------------------------------------------------

    always_comb begin
        joined = entryIn.data ^ keyIn;
        // IV bits of the header stay plain
        if (entryIn.isHeader) begin
            joined[`PC_IV_WIDTH-1:0] = entryIn.data[`PC_IV_WIDTH-1:0];
        end
    end

    assign joinValid   = entryValid && keyValid;
    assign outReadySel = (dir == pathRead) ? backendOutReady : dramOutReady;
    assign entryReady  = keyValid && outReadySel;
    assign keyReady    = entryValid && outReadySel;
    assign outXfer     = joinValid && outReadySel;
    assign lastOut     = outXfer && (outCount == PathBursts - 1'b1);

    assign dramOut         = joined;
    assign dramOutValid    = joinValid && (dir == pathWrite);
    assign backendOut      = joined;
    assign backendOutValid = joinValid && (dir == pathRead);

    // ------------------------------------------------------------------------
    // Path counting and direction
    // ------------------------------------------------------------------------

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            dir      <= pathRead;
            inCount  <= '0;
            outCount <= '0;
        end else if (lastOut) begin
            dir      <= (dir == pathRead) ? pathWrite : pathRead;
            inCount  <= '0;
            outCount <= '0;
        end else begin
            if (inXfer) inCount <= inCount + 1'b1;
            if (outXfer) outCount <= outCount + 1'b1;
        end
    end

    // Every burst of the path went through both FIFOs before the flip
    assert property (@(posedge Clock) disable iff (!rstN)
        lastOut |-> inCount == PathBursts);

endmodule

/* verilog/streamFifo.sv */
// --------------------------------------------------------------------------
// Valid/ready FIFO with a type-parameter payload and occupancy output
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "pathCrypt_macros.svh"

module streamFifo #(
    parameter type Payload = logic [7:0],
    parameter int  Depth   = `PC_FIFO_DEPTH
) (
    input  logic                       Clock,
    input  logic                       rstN,
    input  Payload                     inData,
    input  logic                       inValid,
    output logic                       inReady,
    output Payload                     outData,
    output logic                       outValid,
    input  logic                       outReady,
    output logic [$clog2(Depth+1)-1:0] count
);

    localparam int PtrW = $clog2(Depth);

    Payload          mem [Depth];
    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic            full;
    logic            push;
    logic            pop;

    assign full     = (count == Depth);
    // A full FIFO still takes a burst when the head leaves in the same cycle
    assign inReady  = !full || outReady;
    assign outValid = (count != 0);
    assign outData  = mem[rdPtr];
    assign push     = inValid && inReady;
    assign pop      = outValid && outReady;

    always_ff @(posedge Clock) begin
        if (push) begin
            mem[wrPtr] <= inData;
        end
    end

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == PtrW'(Depth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == PtrW'(Depth - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Producers without a ready input rely on upstream credit
    assert property (@(posedge Clock) disable iff (!rstN)
        inValid && full |-> outReady);

    // Empty means both pointers agree, so no pop ran past the tail
    assert property (@(posedge Clock) disable iff (!rstN)
        count == 0 |-> wrPtr == rdPtr);

endmodule
